// File: tb/audio_stimulus.txt
// Columns: cmd arg data, all hex
// cmd 1 config (arg source_sel, data spk_en), 2 mic sample (data), 3 tone changes (arg),
// 4 spk_l ones count over 65536 cycles (data), 0 end
1 2 1
2 0 0100
2 0 8000
2 0 7FFF
2 0 7FFF
2 0 7FFF
2 0 7FFF
2 0 7FFF
2 0 7FFF
2 0 8000
2 0 7FFF
2 0 8000
2 0 8000
2 0 8000
2 0 8000
2 0 8000
2 0 8000
2 0 7FFF
2 0 1234
2 0 FEDC
2 0 0000
2 0 0001
2 0 FFFF
2 0 5A5A
2 0 A5A5
2 0 0F0F
1 0 3
4 0 8000
1 1 2
3 18 0
1 2 1
2 0 4000
2 0 4000
4 0 C000
1 3 3
2 0 2000
2 0 E000
2 0 7000
2 0 9000
0 0 0

// File: compile.f
common/audio_pkg.sv
i2s_rx/i2s_mic_rx.sv
fir/decimating_fir.sv
rtl/sine_tone_gen.sv
rtl/audio_output_stage.sv
rtl/audio_top.sv
tb/audio_assertions.sv
tb/audio_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := audio_tb
FLIST     := compile.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/audio_tb.sv
module audio_tb
  import audio_pkg::*;
();

  localparam int MAX_WORDS = 384;
  localparam int DENSITY_CYCLES = 65536;

  logic       audio_clk;
  logic       reset;
  logic       mic_data;
  source_t    source_sel;
  logic [1:0] spk_en;
  logic       bclk;
  logic       lrcl;
  logic       spk_l;
  logic       spk_r;
  sample_t    pcm_out;
  logic       pcm_valid;
  sample_t    level_out;

  logic [31:0] stim_mem [MAX_WORDS]; // Records of three words: cmd, arg, data
  sample_t     sample_q [$];         // Samples waiting to be serialised
  sample_t     exp_q [$];            // Expected filter outputs
  sample_t     hist [FIR_TAPS];      // hist[0] is the newest sent sample
  int          pushed;
  int          frames_started;
  int          value_errors;
  int          other_errors;
  int          cycles;
  int          cycle_limit;
  bit          reset_done;
  logic [31:0] model_phase;
  int          model_step;
  sample_t     tone_last;            // Model tone during the previous cycle
  sample_t     filt_exp;             // Last filter result, due on level_out
  bit          filt_due;

  audio_top i_dut (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .mic_data   (mic_data),
    .source_sel (source_sel),
    .spk_en     (spk_en),
    .bclk       (bclk),
    .lrcl       (lrcl),
    .spk_l      (spk_l),
    .spk_r      (spk_r),
    .pcm_out    (pcm_out),
    .pcm_valid  (pcm_valid),
    .level_out  (level_out)
  );

  always #4 audio_clk = ~audio_clk;

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_density(input string name, input int got, input int exp);
    if (got > exp + 1 || got < exp - 1) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // Rounded, saturated 8-tap sum over the sent samples
  function automatic sample_t fir_expected();
    longint acc;
    longint r;
    acc = 0;
    for (int k = 0; k < FIR_TAPS; k++) begin
      acc += longint'(hist[k]) * longint'(fir_coef[k]);
    end
    r = (acc + 64'sd16384) >>> 15;
    if (r > 32767) return 16'sh7FFF;
    if (r < -32768) return 16'sh8000;
    return sample_t'(r);
  endfunction

  function automatic sample_t tone_expected(input logic [31:0] ph);
    logic [3:0]        idx;
    logic signed [7:0] v;
    idx = ph[29:26];
    if (ph[30]) idx = 4'd15 - idx; // Mirror in the odd quadrants
    v = quarter_sine[idx];
    if (ph[31]) v = -v;
    return sample_t'(v) <<< 8;
  endfunction

  task automatic model_push(input sample_t x);
    for (int k = FIR_TAPS - 1; k > 0; k--) hist[k] = hist[k-1];
    hist[0] = x;
    pushed++;
    if (pushed % 2 == 0) exp_q.push_back(fir_expected()); // Decimate by two
  endtask

  task automatic wait_bclk_fall();
    logic prev;
    do begin
      prev = bclk;
      @(posedge audio_clk);
      #1;
    end while (!(prev && !bclk));
  endtask

  task automatic wait_drained();
    int target;
    while (sample_q.size() != 0) @(posedge audio_clk);
    target = frames_started + 2;
    while (frames_started < target) @(posedge audio_clk);
    @(posedge audio_clk);
    #1;
  endtask

  task automatic run_tone_check(input int n);
    sample_t seen;
    int      changes;
    changes = 0;
    @(negedge audio_clk);
    seen = level_out;
    while (changes < n) begin
      @(negedge audio_clk);
      if (level_out !== seen) begin
        check_sample("level_out", level_out, tone_last);
        seen = level_out;
        changes++;
      end
    end
  endtask

  task automatic run_density_check(input int exp);
    int ones;
    ones = 0;
    repeat (DENSITY_CYCLES) begin
      @(negedge audio_clk);
      if (spk_l) ones++;
    end
    check_density("spk_l_ones", ones, exp);
  endtask

  // Tone reference, stepped from reset like the generator
  always @(posedge audio_clk) begin
    tone_last = tone_expected(model_phase);
    if (reset) begin
      model_phase = '0;
      model_step  = 0;
    end else if (model_step == TONE_STEP_DIV - 1) begin
      model_step  = 0;
      model_phase = model_phase + TONE_PHASE_INCR;
    end else begin
      model_step++;
    end
  end

  always @(negedge audio_clk) begin
    if (filt_due) check_sample("level_out", level_out, filt_exp); // Filtered source holds it
    filt_due = 1'b0;
    if (!reset && pcm_valid) begin
      if (exp_q.size() == 0) begin
        $display("pcm_valid pulsed with no filter result expected");
        other_errors++;
      end else begin
        filt_exp = exp_q.pop_front();
        check_sample("pcm_out", pcm_out, filt_exp);
        filt_due = (source_sel == SRC_MIC_FILT);
      end
    end
    if (!reset && !spk_en[1]) check_bit("spk_r", spk_r, 1'b0);
    if (!reset && !spk_en[0]) check_bit("spk_l", spk_l, 1'b0);
  end

  always @(posedge audio_clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Serialises one sample per frame; the last sample repeats when none is queued
  initial begin : frame_driver
    sample_t cur;
    sample_t prev_sample;
    bit      prev_raw;
    bit      have_prev;
    cur = '0;
    prev_sample = '0;
    prev_raw = 1'b0;
    have_prev = 1'b0;
    wait (reset_done);
    forever begin
      if (sample_q.size() > 0) cur = sample_q.pop_front();
      if (have_prev && prev_raw && source_sel == SRC_MIC_RAW) begin
        check_sample("level_out", level_out, prev_sample);
      end
      model_push(cur);
      frames_started++;
      prev_sample = cur;
      prev_raw = (source_sel == SRC_MIC_RAW);
      have_prev = 1'b1;
      for (int pos = 0; pos < FRAME_BITS; pos++) begin
        check_bit("lrcl", lrcl, logic'(pos >= FRAME_BITS / 2));
        if (pos >= 1 && pos <= SAMPLE_BITS) mic_data = cur[SAMPLE_BITS - pos];
        else if (pos >= FRAME_BITS / 2) mic_data = 1'($urandom()); // Right slot filler
        else mic_data = 1'b0;
        wait_bclk_fall();
      end
    end
  end

  initial begin
    int rec;
    int frames;
    int extra;
    logic [31:0] cmd;
    logic [31:0] arg;
    logic [31:0] data;
    void'($urandom(32'h63f0bd45));
    audio_clk = 1'b0;
    reset = 1'b1;
    mic_data = 1'b0;
    source_sel = SRC_SILENCE;
    spk_en = 2'b00;
    pushed = 0;
    frames_started = 0;
    value_errors = 0;
    other_errors = 0;
    cycles = 0;
    cycle_limit = 0;
    reset_done = 1'b0;
    model_phase = '0;
    model_step = 0;
    filt_exp = '0;
    filt_due = 1'b0;
    for (int k = 0; k < FIR_TAPS; k++) hist[k] = '0;
    for (int i = 0; i < MAX_WORDS; i++) stim_mem[i] = '0;
    $readmemh("tb/audio_stimulus.txt", stim_mem);

    // Limit from the file: frames, density windows, tone steps and drain waits
    frames = 0;
    extra = 0;
    for (rec = 0; rec < MAX_WORDS / 3 && stim_mem[rec*3] != 0; rec++) begin
      cmd = stim_mem[rec*3];
      if (cmd == 2) frames++;
      else extra += 4 * 256;
      if (cmd == 3) extra += int'(stim_mem[rec*3+1]) * TONE_STEP_DIV * 2;
      if (cmd == 4) extra += DENSITY_CYCLES + 1024;
    end
    cycle_limit = (frames + 8) * 256 * 2 + extra + 20000;

    repeat (2) @(posedge audio_clk);
    @(negedge audio_clk);
    check_bit("bclk", bclk, 1'b0);
    check_bit("lrcl", lrcl, 1'b0);
    check_bit("pcm_valid", pcm_valid, 1'b0);
    check_bit("spk_l", spk_l, 1'b0);
    check_bit("spk_r", spk_r, 1'b0);
    @(posedge audio_clk);
    #1;
    reset = 1'b0;
    reset_done = 1'b1;
    @(posedge audio_clk);
    #1;

    for (rec = 0; rec < MAX_WORDS / 3; rec++) begin
      cmd = stim_mem[rec*3];
      arg = stim_mem[rec*3+1];
      data = stim_mem[rec*3+2];
      if (cmd == 0) break;
      case (cmd)
        1: begin
          wait_drained();
          source_sel = source_t'(arg[1:0]);
          spk_en = data[1:0];
        end
        2: sample_q.push_back(data[15:0]);
        3: begin
          wait_drained();
          run_tone_check(int'(arg));
        end
        4: begin
          wait_drained();
          run_density_check(int'(data));
        end
        default: begin
          $display("Unknown command %0d in stimulus record %0d", cmd, rec);
          other_errors++;
        end
      endcase
    end
    wait_drained();
    // Only the frame just started may still owe a result
    if (exp_q.size() != ((pushed % 2 == 0) ? 1 : 0)) begin
      $display("Filter results missing, %0d still expected", exp_q.size());
      other_errors++;
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb/audio_assertions.sv
module audio_assertions (
  input logic audio_clk,
  input logic reset,
  input logic bclk,
  input logic lrcl,
  input logic raw_req,
  input logic raw_ack,
  input logic last_bit
);

  int warm; // Cycles since reset, so $past history is valid

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      warm <= 0;
    end else if (warm < 8) begin
      warm <= warm + 1;
    end
  end

  req_hold: assert property (@(posedge audio_clk) disable iff (reset)
    raw_req && !raw_ack |=> raw_req)
    else $error("raw_req dropped before raw_ack");

  ack_hold: assert property (@(posedge audio_clk) disable iff (reset)
    raw_ack && raw_req |=> raw_ack)
    else $error("raw_ack dropped while raw_req high");

  // High two cycles, low two cycles
  bclk_period: assert property (@(posedge audio_clk) disable iff (reset)
    $rose(bclk) && warm >= 8 |->
      !$past(bclk, 2) && $past(bclk, 3) && $past(bclk, 4) && !$past(bclk, 5))
    else $error("bclk period is not 4 cycles");

  lrcl_edge: assert property (@(posedge audio_clk) disable iff (reset)
    $changed(lrcl) |-> $fell(bclk))
    else $error("lrcl changed away from a falling bclk");

  // Ack still high one cycle ago means the release phase is not over
  no_drop: assert property (@(posedge audio_clk) disable iff (reset)
    last_bit |-> !raw_req && !raw_ack && !$past(raw_ack))
    else $error("Frame completed while handshake busy");

endmodule

bind i2s_mic_rx audio_assertions i_assertions (.*);

// File: rtl/audio_top.sv
module audio_top
  import audio_pkg::*;
(
  input  logic       audio_clk,
  input  logic       reset,
  input  logic       mic_data,
  input  source_t    source_sel,
  input  logic [1:0] spk_en,
  output logic       bclk,
  output logic       lrcl,
  output logic       spk_l,
  output logic       spk_r,
  output sample_t    pcm_out,
  output logic       pcm_valid,
  output sample_t    level_out
);

  logic    raw_req;
  logic    raw_ack;
  sample_t raw_sample;
  sample_t tone_sample;

  i2s_mic_rx u_mic_rx (
    .audio_clk  (audio_clk),
    .reset      (reset),
    .mic_data   (mic_data),
    .raw_ack    (raw_ack),
    .bclk       (bclk),
    .lrcl       (lrcl),
    .raw_req    (raw_req),
    .raw_sample (raw_sample)
  );

  // Filtered stream leaves the chip as pcm_out as well
  decimating_fir u_fir (
    .audio_clk   (audio_clk),
    .reset       (reset),
    .raw_req     (raw_req),
    .raw_sample  (raw_sample),
    .raw_ack     (raw_ack),
    .filt_sample (pcm_out),
    .filt_valid  (pcm_valid)
  );

  sine_tone_gen u_tone (
    .audio_clk   (audio_clk),
    .reset       (reset),
    .tone_sample (tone_sample)
  );

  audio_output_stage u_out (
    .audio_clk   (audio_clk),
    .reset       (reset),
    .source_sel  (source_sel),
    .spk_en      (spk_en),
    .tone_sample (tone_sample),
    .raw_sample  (raw_sample),
    .raw_req     (raw_req),
    .raw_ack     (raw_ack),
    .filt_sample (pcm_out),
    .filt_valid  (pcm_valid),
    .spk_l       (spk_l),
    .spk_r       (spk_r),
    .level_out   (level_out)
  );

endmodule

// File: rtl/audio_output_stage.sv
module audio_output_stage
  import audio_pkg::*;
(
  input  logic    audio_clk,
  input  logic    reset,
  input  source_t source_sel,
  input  logic [1:0] spk_en,
  input  sample_t tone_sample,
  input  sample_t raw_sample,
  input  logic    raw_req,
  input  logic    raw_ack,
  input  sample_t filt_sample,
  input  logic    filt_valid,
  output logic    spk_l,
  output logic    spk_r,
  output sample_t level_out
);

  sample_t      held_level;
  sample_t      prev_tone;
  logic [15:0]  pdm_acc;
  logic [15:0]  offset_level;
  logic [16:0]  pdm_sum;
  logic         pdm_bit;

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      prev_tone <= '0;
    end else begin
      prev_tone <= tone_sample;
    end
  end

  // Each source reloads the held level on its own event
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      held_level <= '0;
    end else begin
      case (source_sel)
        SRC_SILENCE: held_level <= '0;
        SRC_TONE: if (tone_sample != prev_tone) held_level <= tone_sample;
        SRC_MIC_RAW: if (raw_req && raw_ack) held_level <= raw_sample; // Handshake cycle
        SRC_MIC_FILT: if (filt_valid) held_level <= filt_sample;
        default: held_level <= '0;
      endcase
    end
  end

  assign level_out = held_level;

  // First-order sigma-delta, carry out is the PDM bit
  assign offset_level = {~held_level[15], held_level[14:0]};
  assign pdm_sum      = {1'b0, pdm_acc} + {1'b0, offset_level};

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      pdm_acc <= '0;
      pdm_bit <= 1'b0;
    end else begin
      pdm_acc <= pdm_sum[15:0];
      pdm_bit <= pdm_sum[16];
    end
  end

  assign spk_l = spk_en[0] & pdm_bit;
  assign spk_r = spk_en[1] & pdm_bit;

endmodule

// File: rtl/sine_tone_gen.sv
module sine_tone_gen
  import audio_pkg::*;
(
  input  logic    audio_clk,
  input  logic    reset,
  output sample_t tone_sample
);

  logic [TONE_DIV_W-1:0]  step_cnt;
  logic [31:0]            phase;
  logic [1:0]             quadrant;
  logic [3:0]             table_idx;
  logic signed [7:0]      quarter_val;
  logic signed [7:0]      sine_val;

  // Phase only moves once per TONE_STEP_DIV cycles
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      step_cnt <= '0;
      phase    <= '0;
    end else if (step_cnt == TONE_DIV_W'(TONE_STEP_DIV - 1)) begin
      step_cnt <= '0;
      phase    <= phase + TONE_PHASE_INCR;
    end else begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  assign quadrant = phase[31:30];

  // Odd quadrants run the table backwards
  assign table_idx   = quadrant[0] ? ~phase[29:26] : phase[29:26];
  assign quarter_val = quarter_sine[table_idx];
  assign sine_val    = quadrant[1] ? -quarter_val : quarter_val; // Lower half cycle

  assign tone_sample = {sine_val, 8'h00}; // Same as sign extend then shift by 8

endmodule

// File: fir/decimating_fir.sv
module decimating_fir
  import audio_pkg::*;
(
  input  logic    audio_clk,
  input  logic    reset,
  input  logic    raw_req,
  input  sample_t raw_sample,
  output logic    raw_ack,
  output sample_t filt_sample,
  output logic    filt_valid
);

  sample_t                      dline [FIR_TAPS]; // dline[0] is the newest sample
  logic signed [FIR_ACC_W-1:0]  acc;
  logic signed [FIR_ACC_W-1:0]  rounded;
  logic signed [31:0]           prod;
  logic [TAP_IDX_W-1:0]         mac_idx;
  logic                         mac_busy;
  logic                         mac_done;
  logic                         odd_input; // Set after the 1st, 3rd ... input
  logic                         take;
  sample_t                      sat_result;

  // Sample is taken in the cycle req is seen, ack follows one cycle later
  assign take = raw_req && !raw_ack;

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      raw_ack <= 1'b0;
    end else begin
      raw_ack <= raw_req;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (reset) begin
      for (int i = 0; i < FIR_TAPS; i++) begin
        dline[i] <= '0;
      end
    end else if (take) begin
      dline[0] <= raw_sample;
      for (int i = 1; i < FIR_TAPS; i++) begin
        dline[i] <= dline[i-1];
      end
    end
  end

  assign prod = dline[mac_idx] * fir_coef[mac_idx];

  // One tap per cycle, FIR_TAPS cycles per input
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      mac_idx   <= '0;
      mac_busy  <= 1'b0;
      mac_done  <= 1'b0;
      odd_input <= 1'b0;
    end else begin
      mac_done <= 1'b0;
      if (take) begin
        mac_idx   <= '0;
        mac_busy  <= 1'b1;
        odd_input <= ~odd_input;
      end else if (mac_busy) begin
        mac_idx <= mac_idx + 1'b1;
        if (mac_idx == TAP_IDX_W'(FIR_TAPS - 1)) begin
          mac_busy <= 1'b0;
          mac_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (take) begin
      acc <= '0;
    end else if (mac_busy) begin
      acc <= acc + FIR_ACC_W'(prod);
    end
  end

  // Round to nearest, drop 15 fraction bits, clamp to 16 bits
  always_comb begin
    rounded = (acc + (FIR_ACC_W'(1) <<< 14)) >>> 15;
    if (rounded > FIR_ACC_W'(32767)) begin
      sat_result = 16'sh7FFF;
    end else if (rounded < -FIR_ACC_W'(32768)) begin
      sat_result = 16'sh8000;
    end else begin
      sat_result = rounded[15:0];
    end
  end

  // Publish on every second input only
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      filt_valid <= 1'b0;
    end else begin
      filt_valid <= mac_done && !odd_input;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (mac_done && !odd_input) begin
      filt_sample <= sat_result;
    end
  end

endmodule

// File: i2s_rx/i2s_mic_rx.sv
module i2s_mic_rx
  import audio_pkg::*;
(
  input  logic    audio_clk,
  input  logic    reset,
  input  logic    mic_data,
  input  logic    raw_ack,
  output logic    bclk,
  output logic    lrcl,
  output logic    raw_req,
  output sample_t raw_sample
);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,     // raw_req high, waiting for ack
    HS_RELEASE  // raw_req low, waiting for ack to drop
  } hs_state_t;

  hs_state_t                hs_state;
  logic [BCLK_DIV_W-1:0]    div_cnt;
  logic [BIT_CNT_W-1:0]     bit_cnt;
  logic [SAMPLE_BITS-2:0]   shift_reg;
  logic                     half_tick;
  logic                     bclk_rise;
  logic                     bclk_fall;
  logic                     capture;
  logic                     last_bit;

  assign half_tick = (div_cnt == BCLK_DIV_W'(BCLK_HALF - 1));
  assign bclk_rise = half_tick && !bclk;
  assign bclk_fall = half_tick && bclk;

  // Slot bit 0 is the I2S delay bit, bits 1..16 carry the sample MSB first
  assign capture  = bclk_rise && (bit_cnt != '0) &&
                    (bit_cnt <= BIT_CNT_W'(SAMPLE_BITS));
  assign last_bit = capture && (bit_cnt == BIT_CNT_W'(SAMPLE_BITS));

  assign lrcl    = bit_cnt[BIT_CNT_W-1]; // Low for the left slot
  assign raw_req = (hs_state == HS_REQ);

  // Bit clock divider
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      div_cnt <= '0;
      bclk    <= 1'b0;
    end else if (half_tick) begin
      div_cnt <= '0;
      bclk    <= ~bclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Bit position advances on the falling bclk edge, so lrcl moves there too
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift_reg <= {shift_reg[SAMPLE_BITS-3:0], mic_data};
    end
  end

  // Four-phase handshake; a frame finishing while busy is dropped
  always_ff @(posedge audio_clk) begin
    if (reset) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE: if (last_bit) hs_state <= HS_REQ;
        HS_REQ: if (raw_ack) hs_state <= HS_RELEASE;
        HS_RELEASE: if (!raw_ack) hs_state <= HS_IDLE;
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge audio_clk) begin
    if (last_bit && hs_state == HS_IDLE) begin
      raw_sample <= {shift_reg, mic_data};
    end
  end

endmodule

// File: common/audio_pkg.sv
package audio_pkg;

  typedef logic signed [15:0] sample_t; // Two's complement PCM

  typedef enum logic [1:0] {
    SRC_SILENCE  = 2'd0,
    SRC_TONE     = 2'd1,
    SRC_MIC_RAW  = 2'd2,
    SRC_MIC_FILT = 2'd3
  } source_t;

  // I2S framing
  localparam int BCLK_HALF   = 2;  // audio_clk cycles per bclk half period
  localparam int FRAME_BITS  = 64; // Bit clocks per lrcl period
  localparam int SAMPLE_BITS = 16;
  localparam int BCLK_DIV_W  = $clog2(BCLK_HALF);
  localparam int BIT_CNT_W   = $clog2(FRAME_BITS);

  // Anti-alias FIR, Q1.15 coefficients summing to unity gain
  localparam int FIR_TAPS  = 8;
  localparam int TAP_IDX_W = $clog2(FIR_TAPS);
  localparam int FIR_ACC_W = 32 + TAP_IDX_W; // Q2.30 sum plus growth
  localparam sample_t fir_coef [FIR_TAPS] = '{
    -16'sd512, 16'sd1024, 16'sd5120, 16'sd10752,
    16'sd10752, 16'sd5120, 16'sd1024, -16'sd512
  };

  // Tone generator
  localparam int TONE_STEP_DIV = 64;
  localparam int TONE_DIV_W    = $clog2(TONE_STEP_DIV);
  localparam logic [31:0] TONE_PHASE_INCR = 32'h04B1_7E4B;

  // First quadrant of a sine, 127 full scale
  localparam logic signed [7:0] quarter_sine [16] = '{
    8'sd0,   8'sd12,  8'sd25,  8'sd37,  8'sd49,  8'sd60,  8'sd71,  8'sd81,
    8'sd90,  8'sd98,  8'sd106, 8'sd112, 8'sd117, 8'sd122, 8'sd125, 8'sd126
  };

endpackage
